// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_saturn_nibble_decoder
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== src/nibble_if.sv ====
// nibble interface between the sequencer and the classifier
// the sequencer presents the nibble and its position, the classifier answers
`timescale 1ns/100ps

interface nibble_if import saturn_decode_pkg::*; ();

    logic     valid;                                // one accepted nibble this cycle
    nibble_t  nib;
    nibble_t  first_nib;                            // opcode nibble of the current instruction
    nib_pos_t pos;
    logic     last;                                 // countdown is on its final operand

    uop_t     uop;
    nibble_t  operands;                             // nibbles still to follow
    logic     done;
    logic     start_exec;
    logic     illegal;

    modport seq (
        output valid, nib, first_nib, pos, last,
        input  operands, done, start_exec, illegal
    );

    modport cls (
        input  valid, nib, first_nib, pos, last,
        output uop, operands, done, start_exec, illegal
    );

endinterface

// ==== src/nibble_sequencer.sv ====
// nibble sequencer
// tracks where each nibble sits in its instruction and counts the operand nibbles
`timescale 1ns/100ps

module nibble_sequencer import saturn_decode_pkg::*; (
    input  logic    i_clk,
    input  logic    i_reset,
    input  logic    i_nibble_valid,
    input  nibble_t i_nibble,
    nibble_if.seq   bus
);

    nib_pos_t pos_q;
    nibble_t  first_q;
    nibble_t  count_q;                              // operand nibbles left, minus one

    // ##################################################
    // presentation to the classifier

    assign bus.valid     = i_nibble_valid;
    assign bus.nib       = i_nibble;
    assign bus.pos       = pos_q;
    assign bus.last      = (count_q == 4'd0);

    // at the first nibble the opcode is the nibble on the bus itself
    assign bus.first_nib = (pos_q == POS_FIRST) ? i_nibble : first_q;

    // ##################################################
    // position state and countdown

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pos_q   <= POS_FIRST;
            count_q <= 4'd0;
        end else if (i_nibble_valid) begin
            if (bus.done || bus.illegal) begin
                pos_q <= POS_FIRST;                 // instruction over, next nibble is an opcode
            end else if (bus.start_exec) begin
                pos_q <= POS_OPERAND;               // jump offset or LC data follows
            end else if (pos_q == POS_FIRST) begin
                pos_q <= POS_SECOND;
            end

            if (bus.start_exec) begin
                // LC with n=15 wraps operands to 0, which reloads 15 for sixteen nibbles
                count_q <= bus.operands - 4'd1;
            end else if (pos_q == POS_OPERAND) begin
                count_q <= count_q - 4'd1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_nibble_valid && pos_q == POS_FIRST) begin
            first_q <= i_nibble;                    // kept for the second and operand nibbles
        end
    end

endmodule

// ==== src/opcode_classifier.sv ====
// opcode classifier
// maps the first or second nibble of an instruction to a micro-operation
// and tells the sequencer how many operand nibbles follow
`timescale 1ns/100ps

module opcode_classifier import saturn_decode_pkg::*; (
    nibble_if.cls    bus,
    input  nibble_t  i_reg_p,
    output uop_t     o_uop,
    output logic     o_valid,
    output nib_pos_t o_pos,
    output logic     o_done,
    output logic     o_start_exec,
    output logic     o_illegal
);

    logic [1:0] sel_b;                              // register pair selector
    logic [1:0] sel_u;                              // operation selector within a group
    alu_reg_t   regs_abcd;
    alu_reg_t   regs_bcac;
    alu_reg_t   regs_abac;
    alu_reg_t   regs_bccd;

    uop_t       uop_c;
    nibble_t    ops_c;
    logic       done_c;
    logic       start_c;
    logic       illegal_c;

    assign sel_b = bus.nib[1:0];
    assign sel_u = bus.nib[3:2];

    // ##################################################
    // register maps of the field A groups

    assign regs_abcd = alu_reg_t'({3'b000, sel_b});
    assign regs_bcac = alu_reg_t'({3'b000, sel_b[0], !(sel_b[1] | sel_b[0])});
    assign regs_abac = alu_reg_t'({3'b000, sel_b[1] & sel_b[0], !sel_b[1] & sel_b[0]});
    assign regs_bccd = alu_reg_t'({3'b000, sel_b[1] | sel_b[0], !sel_b[1] ^ sel_b[0]});

    // ##################################################
    // classification

    always_comb begin
        uop_c     = UOP_IDLE;
        ops_c     = 4'd0;
        done_c    = 1'b0;
        start_c   = 1'b0;
        illegal_c = 1'b0;

        case (bus.pos)
            POS_FIRST: begin
                case (bus.nib)
                    4'h2, 4'h3, 4'hC, 4'hD, 4'hF: illegal_c = 1'b0;    // second nibble decides
                    4'h6, 4'h7: begin
                        uop_c.instr_type = INSTR_TYPE_JUMP;
                        uop_c.push_pc    = bus.nib[0];  // 7 is GOSUB
                        ops_c            = JUMP_OPERANDS;
                        start_c          = 1'b1;
                    end
                    default: illegal_c = 1'b1;
                endcase
            end
            POS_SECOND: begin
                case (bus.first_nib)
                    4'h2: begin                         // P= n
                        uop_c.instr_type = INSTR_TYPE_ALU;
                        uop_c.dest       = ALU_REG_P;
                        uop_c.src_1      = ALU_REG_IMM;
                        uop_c.imm        = bus.nib;
                        uop_c.opcode     = ALU_OP_COPY;
                        done_c           = 1'b1;
                    end
                    4'h3: begin                         // LC, n+1 digits into C from P up
                        uop_c.instr_type = INSTR_TYPE_LOAD;
                        uop_c.dest       = ALU_REG_C;
                        uop_c.src_1      = ALU_REG_IMM;
                        uop_c.opcode     = ALU_OP_COPY;
                        uop_c.ptr_begin  = i_reg_p;
                        uop_c.ptr_end    = i_reg_p + bus.nib;
                        ops_c            = bus.nib + 4'd1;
                        start_c          = 1'b1;
                    end
                    4'hC, 4'hD, 4'hF: begin
                        uop_c.instr_type = INSTR_TYPE_ALU;
                        uop_c.field      = ALU_FIELD_A;
                        uop_c.ptr_begin  = FIELD_A_BEGIN;
                        uop_c.ptr_end    = FIELD_A_END;
                        uop_c.dest       = regs_abcd;
                        uop_c.src_1      = regs_abcd;
                        done_c           = 1'b1;
                        if (bus.first_nib == 4'hC) begin
                            uop_c.opcode = (sel_u == 2'd3) ? ALU_OP_DEC : ALU_OP_ADD;
                            case (sel_u)
                                2'd0: uop_c.src_2 = regs_bcac;
                                2'd1: uop_c.src_2 = regs_abcd;
                                2'd2: begin
                                    uop_c.dest  = regs_bcac;
                                    uop_c.src_1 = regs_bcac;
                                    uop_c.src_2 = regs_abcd;
                                end
                                default: uop_c.src_2 = ALU_REG_NONE;
                            endcase
                        end else if (bus.first_nib == 4'hD) begin
                            case (sel_u)
                                2'd0: begin
                                    uop_c.opcode = ALU_OP_ZERO;
                                    uop_c.src_1  = ALU_REG_NONE;
                                end
                                2'd1: begin
                                    uop_c.opcode = ALU_OP_COPY;
                                    uop_c.src_1  = regs_bcac;
                                end
                                2'd2: begin
                                    uop_c.opcode = ALU_OP_COPY;
                                    uop_c.dest   = regs_bcac;
                                end
                                default: begin
                                    uop_c.opcode = ALU_OP_EXCH;
                                    uop_c.dest   = regs_abac;
                                    uop_c.src_1  = regs_abac;
                                    uop_c.src_2  = regs_bccd;
                                end
                            endcase
                        end else begin
                            case (sel_u)
                                2'd0:    uop_c.opcode = ALU_OP_SHL;
                                2'd1:    uop_c.opcode = ALU_OP_SHR;
                                2'd2:    uop_c.opcode = ALU_OP_TWOS_CMPL;
                                default: uop_c.opcode = ALU_OP_ONES_CMPL;
                            endcase
                        end
                    end
                    default: illegal_c = 1'b1;          // no other group reaches this position
                endcase
            end
            default: begin
                uop_c.imm = bus.nib;                    // LC data, ignored for jump offsets
                done_c    = bus.last;
            end
        endcase
    end

    // ##################################################
    // results, flags only count on a valid nibble

    assign bus.uop        = uop_c;
    assign bus.operands   = ops_c;
    assign bus.done       = bus.valid && done_c;
    assign bus.start_exec = bus.valid && start_c;
    assign bus.illegal    = bus.valid && illegal_c;

    assign o_uop          = bus.uop;
    assign o_valid        = bus.valid;
    assign o_pos          = bus.pos;
    assign o_done         = bus.done;
    assign o_start_exec   = bus.start_exec;
    assign o_illegal      = bus.illegal;

endmodule

// ==== src/saturn_decode_pkg.sv ====
// decoder package
// register, opcode, instruction type and field encodings
// nibble, micro-operation and position types, field A span and jump length
package saturn_decode_pkg;

    typedef logic [3:0] nibble_t;                   // one bus nibble, also a digit pointer

    typedef enum logic [4:0] {
        ALU_REG_A    = 5'd0,
        ALU_REG_B    = 5'd1,
        ALU_REG_C    = 5'd2,
        ALU_REG_D    = 5'd3,
        ALU_REG_P    = 5'd4,
        ALU_REG_ST   = 5'd5,
        ALU_REG_IMM  = 5'd6,                        // operand comes from the immediate nibble
        ALU_REG_NONE = 5'd31
    } alu_reg_t;

    typedef enum logic [4:0] {
        ALU_OP_NOP       = 5'd0,
        ALU_OP_COPY      = 5'd1,
        ALU_OP_ZERO      = 5'd2,
        ALU_OP_ADD       = 5'd3,
        ALU_OP_DEC       = 5'd4,
        ALU_OP_EXCH      = 5'd5,
        ALU_OP_SHL       = 5'd6,
        ALU_OP_SHR       = 5'd7,
        ALU_OP_TWOS_CMPL = 5'd8,
        ALU_OP_ONES_CMPL = 5'd9
    } alu_op_t;

    typedef enum logic [3:0] {
        INSTR_TYPE_ALU  = 4'd0,
        INSTR_TYPE_LOAD = 4'd1,
        INSTR_TYPE_JUMP = 4'd2,
        INSTR_TYPE_NONE = 4'd15                     // idle, nothing decoded
    } instr_type_t;

    typedef enum logic [3:0] {
        ALU_FIELD_NONE = 4'h0,
        ALU_FIELD_A    = 4'hF
    } alu_field_t;

    typedef enum logic [1:0] {
        POS_FIRST   = 2'd0,
        POS_SECOND  = 2'd1,
        POS_OPERAND = 2'd2                          // LC data or jump offset nibble
    } nib_pos_t;

    typedef struct packed {
        instr_type_t instr_type;
        alu_reg_t    dest;
        alu_reg_t    src_1;
        alu_reg_t    src_2;
        alu_field_t  field;
        nibble_t     ptr_begin;
        nibble_t     ptr_end;
        nibble_t     imm;
        alu_op_t     opcode;
        logic        push_pc;                       // GOSUB saves the return address
    } uop_t;

    // field A covers the five low digits of a register
    localparam nibble_t FIELD_A_BEGIN = 4'd0;
    localparam nibble_t FIELD_A_END   = 4'd4;
    localparam nibble_t JUMP_OPERANDS = 4'd3;

    localparam uop_t UOP_IDLE = '{
        instr_type: INSTR_TYPE_NONE,
        dest:       ALU_REG_NONE,
        src_1:      ALU_REG_NONE,
        src_2:      ALU_REG_NONE,
        field:      ALU_FIELD_NONE,
        ptr_begin:  4'd0,
        ptr_end:    4'd0,
        imm:        4'd0,
        opcode:     ALU_OP_NOP,
        push_pc:    1'b0
    };

endpackage

// ==== src/saturn_nibble_decoder.sv ====
// nibble-serial Saturn instruction decoder, top level
// sequencer, classifier and result register joined by one nibble interface
`timescale 1ns/100ps

module saturn_nibble_decoder import saturn_decode_pkg::*; (
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_nibble_valid,
    input  nibble_t     i_nibble,
    input  nibble_t     i_reg_p,
    output instr_type_t o_instr_type,
    output alu_reg_t    o_alu_reg_dest,
    output alu_reg_t    o_alu_reg_src_1,
    output alu_reg_t    o_alu_reg_src_2,
    output alu_field_t  o_alu_field,
    output nibble_t     o_alu_ptr_begin,
    output nibble_t     o_alu_ptr_end,
    output nibble_t     o_alu_imm_value,
    output alu_op_t     o_alu_opcode,
    output logic        o_push_pc,
    output nibble_t     o_load_ptr,
    output logic        o_imm_valid,
    output logic        o_instr_decoded,
    output logic        o_instr_execute,
    output logic        o_decoder_error
);

    nibble_if bus_if ();

    uop_t     cls_uop;
    logic     cls_valid;
    nib_pos_t cls_pos;
    logic     cls_done;
    logic     cls_start_exec;
    logic     cls_illegal;
    uop_t     dec_uop;                              // registered decode result

    nibble_sequencer u_sequencer (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_nibble_valid (i_nibble_valid),
        .i_nibble       (i_nibble),
        .bus            (bus_if.seq)
    );

    opcode_classifier u_classifier (
        .bus          (bus_if.cls),
        .i_reg_p      (i_reg_p),
        .o_uop        (cls_uop),
        .o_valid      (cls_valid),
        .o_pos        (cls_pos),
        .o_done       (cls_done),
        .o_start_exec (cls_start_exec),
        .o_illegal    (cls_illegal)
    );

    uop_register u_uop_register (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_uop           (cls_uop),
        .i_valid         (cls_valid),
        .i_pos           (cls_pos),
        .i_done          (cls_done),
        .i_start_exec    (cls_start_exec),
        .i_illegal       (cls_illegal),
        .o_uop           (dec_uop),
        .o_load_ptr      (o_load_ptr),
        .o_imm_valid     (o_imm_valid),
        .o_instr_decoded (o_instr_decoded),
        .o_instr_execute (o_instr_execute),
        .o_decoder_error (o_decoder_error)
    );

    assign o_instr_type    = dec_uop.instr_type;
    assign o_alu_reg_dest  = dec_uop.dest;
    assign o_alu_reg_src_1 = dec_uop.src_1;
    assign o_alu_reg_src_2 = dec_uop.src_2;
    assign o_alu_field     = dec_uop.field;
    assign o_alu_ptr_begin = dec_uop.ptr_begin;
    assign o_alu_ptr_end   = dec_uop.ptr_end;
    assign o_alu_imm_value = dec_uop.imm;
    assign o_alu_opcode    = dec_uop.opcode;
    assign o_push_pc       = dec_uop.push_pc;

endmodule

// ==== src/uop_register.sv ====
// decoded micro-operation register
// holds the decoded fields, steps the LC load pointer and forms the status pulses
`timescale 1ns/100ps

module uop_register import saturn_decode_pkg::*; (
    input  logic     i_clk,
    input  logic     i_reset,
    input  uop_t     i_uop,
    input  logic     i_valid,
    input  nib_pos_t i_pos,
    input  logic     i_done,
    input  logic     i_start_exec,
    input  logic     i_illegal,
    output uop_t     o_uop,
    output nibble_t  o_load_ptr,
    output logic     o_imm_valid,
    output logic     o_instr_decoded,
    output logic     o_instr_execute,
    output logic     o_decoder_error
);

    uop_t    uop_q;
    nibble_t load_ptr_q;
    logic    load_started_q;                        // a data nibble of this LC went out
    logic    imm_valid_q;
    logic    decoded_q;
    logic    execute_q;
    logic    error_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            uop_q          <= UOP_IDLE;
            load_ptr_q     <= 4'd0;
            load_started_q <= 1'b0;
            imm_valid_q    <= 1'b0;
            decoded_q      <= 1'b0;
            execute_q      <= 1'b0;
            error_q        <= 1'b0;
        end else begin
            decoded_q   <= i_valid && i_done;
            error_q     <= i_valid && i_illegal;
            imm_valid_q <= 1'b0;

            // ##################################################
            // decoded fields and LC data stream

            if (i_valid && i_pos != POS_OPERAND) begin
                uop_q          <= i_uop;            // opcode or second nibble
                load_started_q <= 1'b0;
            end else if (i_valid && uop_q.instr_type == INSTR_TYPE_LOAD) begin
                uop_q.imm      <= i_uop.imm;
                imm_valid_q    <= 1'b1;
                load_started_q <= 1'b1;
                // the first digit lands at P, each following one a digit higher
                load_ptr_q     <= load_started_q ? load_ptr_q + 4'd1 : uop_q.ptr_begin;
            end

            // ##################################################
            // execute window

            if (i_valid && (i_start_exec || i_done)) begin
                execute_q <= 1'b1;                  // a back to back instruction keeps it high
            end else if (decoded_q) begin
                execute_q <= 1'b0;
            end
        end
    end

    assign o_uop           = uop_q;
    assign o_load_ptr      = load_ptr_q;
    assign o_imm_valid     = imm_valid_q;
    assign o_instr_decoded = decoded_q;
    assign o_instr_execute = execute_q;
    assign o_decoder_error = error_q;

endmodule

// ==== test/decoder_testdata.txt ====
# count nibbles p | type dest src1 src2 opcode begin end push_pc | error
# all values hex, nibbles in drive order from left to right
2 25 5 0 04 06 1f 01 0 0 0 0
1 0 0 0 00 00 00 00 0 0 0 1
2 c0 1 0 00 00 01 03 0 4 0 0
2 c5 2 0 01 01 01 03 0 4 0 0
1 1 0 0 00 00 00 00 0 0 0 1
2 ca 3 0 00 00 02 03 0 4 0 0
2 cf 4 0 03 03 1f 04 0 4 0 0
1 4 0 0 00 00 00 00 0 0 0 1
2 d2 6 0 02 1f 1f 02 0 4 0 0
2 d7 7 0 03 02 1f 01 0 4 0 0
1 5 0 0 00 00 00 00 0 0 0 1
2 d8 8 0 01 00 1f 01 0 4 0 0
2 dd 9 0 01 01 02 05 0 4 0 0
2 df a 0 02 02 03 05 0 4 0 0
1 8 0 0 00 00 00 00 0 0 0 1
2 f0 b 0 00 00 1f 06 0 4 0 0
2 f5 c 0 01 01 1f 07 0 4 0 0
1 9 0 0 00 00 00 00 0 0 0 1
2 fa d 0 02 02 1f 08 0 4 0 0
2 ff e 0 03 03 1f 09 0 4 0 0
1 a 0 0 00 00 00 00 0 0 0 1
3 309 7 1 02 06 1f 01 7 7 0 0
5 32abc 3 1 02 06 1f 01 3 5 0 0
1 b 0 0 00 00 00 00 0 0 0 1
6 331234 e 1 02 06 1f 01 e 1 0 0
f 3c0123456789abc 9 1 02 06 1f 01 9 5 0 0
1 e 0 0 00 00 00 00 0 0 0 1
4 6123 0 2 1f 1f 1f 00 0 0 0 0
4 7fa0 4 2 1f 1f 1f 00 0 0 1 0
2 2a 3 0 04 06 1f 01 0 0 0 0

// ==== test/tb_saturn_nibble_decoder.sv ====
// testbench for the nibble-serial decoder
// instructions, P values and expected fields come from the testdata file
// nibbles go in with random idle gaps, results are checked after each instruction
`timescale 1ns/100ps

module tb_saturn_nibble_decoder import saturn_decode_pkg::*; ();

    localparam int RESET_CYCLES   = 16;
    localparam int RESULT_TIMEOUT = 60;               // cycles allowed after the last nibble
    localparam int SETTLE_CYCLES  = 3;

    logic        i_clk;
    logic        i_reset;
    logic        i_nibble_valid;
    nibble_t     i_nibble;
    nibble_t     i_reg_p;
    instr_type_t o_instr_type;
    alu_reg_t    o_alu_reg_dest;
    alu_reg_t    o_alu_reg_src_1;
    alu_reg_t    o_alu_reg_src_2;
    alu_field_t  o_alu_field;
    nibble_t     o_alu_ptr_begin;
    nibble_t     o_alu_ptr_end;
    nibble_t     o_alu_imm_value;
    alu_op_t     o_alu_opcode;
    logic        o_push_pc;
    nibble_t     o_load_ptr;
    logic        o_imm_valid;
    logic        o_instr_decoded;
    logic        o_instr_execute;
    logic        o_decoder_error;

    integer      seed = 50;
    int          errors;
    int          passed;
    int          failed;
    int          accepted;                            // nibbles sampled by the DUT so far
    int          decoded_count;
    int          error_count;
    int          decode_at;                           // value of accepted at the last decoded pulse
    int          exec_rise_at;                        // value of accepted when execute last rose
    logic        exec_prev;
    nibble_t     got_imm[$];
    nibble_t     got_ptr[$];

    // current vector from the data file
    int          v_count;
    logic [63:0] v_nibs;
    int          v_p;
    int          v_type;
    int          v_dest;
    int          v_src1;
    int          v_src2;
    int          v_op;
    int          v_begin;
    int          v_end;
    int          v_push;
    int          v_err;

    saturn_nibble_decoder DUT (.*);

    always #2 i_clk = ~i_clk;

    // ##################################################
    // monitors

    always @(posedge i_clk) begin
        if (i_reset) begin
            accepted <= 0;
        end else if (i_nibble_valid) begin
            accepted <= accepted + 1;                 // same sample the DUT takes at this edge
        end
    end

    always @(negedge i_clk) begin
        if (i_reset) begin
            exec_prev = 1'b0;
        end else begin
            if (o_imm_valid) begin
                got_imm.push_back(o_alu_imm_value);
                got_ptr.push_back(o_load_ptr);
            end
            if (o_decoder_error) error_count = error_count + 1;
            if (o_instr_decoded) begin
                decoded_count = decoded_count + 1;
                decode_at     = accepted;
            end
            if (o_instr_execute && !exec_prev) begin
                exec_rise_at = accepted;
            end
            exec_prev = o_instr_execute;
        end
    end

    // ##################################################
    // helpers

    task automatic report_mismatch(input string what, input int got, input int exp);
        $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("failure at %0t ns: %s", $time, what);
        errors++;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            passed++;
            $display("%s passed", name);
        end else begin
            failed++;
            $display("%s FAILED", name);
        end
    endtask

    task automatic drive_instruction();
        int gap;
        for (int i = 0; i < v_count; i++) begin
            gap = {$random(seed)} % 4;
            repeat (gap) begin
                @(posedge i_clk);
                i_nibble_valid <= 1'b0;
            end
            @(posedge i_clk);
            i_nibble_valid <= 1'b1;
            i_nibble       <= v_nibs[4*(v_count-1-i) +: 4];
            i_reg_p        <= v_p[3:0];
        end
        @(posedge i_clk);
        i_nibble_valid <= 1'b0;
    endtask

    task automatic wait_for_result(input int dec_base, input int err_base, output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < RESULT_TIMEOUT) begin
            @(posedge i_clk);
            cycles++;
            seen = (decoded_count != dec_base) || (error_count != err_base);
        end
    endtask

    task automatic run_line(input int number);
        int         errors_before;
        int         dec_base;
        int         err_base;
        int         imm_base;
        int         acc_base;
        int         n_data;
        bit         seen;
        nibble_t    first;
        nibble_t    second;
        alu_field_t exp_field;
        string      name;
        first         = v_nibs[4*(v_count-1) +: 4];
        second        = (v_count > 1) ? v_nibs[4*(v_count-2) +: 4] : 4'h0;
        name          = $sformatf("test %0d (%0h)", number, v_nibs);
        errors_before = errors;
        dec_base      = decoded_count;
        err_base      = error_count;
        imm_base      = got_imm.size();
        acc_base      = accepted;
        drive_instruction();
        wait_for_result(dec_base, err_base, seen);
        if (!seen) report_failure("no decoded or error pulse came before the timeout");
        repeat (SETTLE_CYCLES) @(posedge i_clk);
        @(negedge i_clk);
        if (v_err != 0) begin
            if (error_count - err_base != 1)
                report_mismatch("error pulse count", error_count - err_base, 1);
            if (decoded_count != dec_base) report_failure("decoded pulsed for an illegal opcode");
        end else begin
            exp_field = (first == 4'hC || first == 4'hD || first == 4'hF) ?
                        ALU_FIELD_A : ALU_FIELD_NONE;
            if (decoded_count - dec_base != 1)
                report_mismatch("decoded pulse count", decoded_count - dec_base, 1);
            if (error_count != err_base) report_failure("decoder error pulsed for a legal opcode");
            if (decode_at != acc_base + v_count)
                report_mismatch("nibbles taken at decode", decode_at - acc_base, v_count);
            if (o_instr_type !== v_type[3:0])
                report_mismatch("type", 32'(o_instr_type), v_type);
            if (o_alu_reg_dest !== v_dest[4:0])
                report_mismatch("destination", 32'(o_alu_reg_dest), v_dest);
            if (o_alu_reg_src_1 !== v_src1[4:0])
                report_mismatch("source 1", 32'(o_alu_reg_src_1), v_src1);
            if (o_alu_reg_src_2 !== v_src2[4:0])
                report_mismatch("source 2", 32'(o_alu_reg_src_2), v_src2);
            if (o_alu_opcode !== v_op[4:0])
                report_mismatch("opcode", 32'(o_alu_opcode), v_op);
            if (o_alu_ptr_begin !== v_begin[3:0])
                report_mismatch("begin pointer", 32'(o_alu_ptr_begin), v_begin);
            if (o_alu_ptr_end !== v_end[3:0])
                report_mismatch("end pointer", 32'(o_alu_ptr_end), v_end);
            if (o_push_pc !== v_push[0])
                report_mismatch("push pc", 32'(o_push_pc), v_push);
            if (o_alu_field !== exp_field)
                report_mismatch("field", 32'(o_alu_field), 32'(exp_field));
            if (first == 4'h2 && o_alu_imm_value !== second)
                report_mismatch("P= immediate", 32'(o_alu_imm_value), 32'(second));
            if ((first == 4'h6 || first == 4'h7) && exec_rise_at != acc_base + 1)
                report_mismatch("nibbles taken when execute rose", exec_rise_at - acc_base, 1);
            if (first == 4'h3) begin
                n_data = int'(second) + 1;            // LC n carries n+1 digits
                if (got_imm.size() - imm_base != n_data) begin
                    report_mismatch("LC data pulse count", got_imm.size() - imm_base, n_data);
                end else begin
                    for (int k = 0; k < n_data; k++) begin
                        if (got_imm[imm_base+k] !== v_nibs[4*(v_count-3-k) +: 4])
                            report_mismatch("LC data nibble", 32'(got_imm[imm_base+k]),
                                            32'(v_nibs[4*(v_count-3-k) +: 4]));
                        if (got_ptr[imm_base+k] !== 4'(v_p + k))
                            report_mismatch("load pointer", 32'(got_ptr[imm_base+k]),
                                            32'(4'(v_p + k)));
                    end
                end
            end else if (got_imm.size() != imm_base) begin
                report_failure("imm_valid pulsed outside an LC instruction");
            end
        end
        finish_test(name, errors_before);
    endtask

    // ##################################################
    // main sequence

    initial begin
        int    fd;
        int    fields;
        int    number;
        int    errors_before;
        string line;
        i_clk          = 1'b0;
        i_reset        <= 1'b1;
        i_nibble_valid <= 1'b0;
        i_nibble       <= 4'h0;
        i_reg_p        <= 4'h0;
        number         = 0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_reset <= 1'b0;
        @(negedge i_clk);
        errors_before = errors;
        if (o_instr_decoded !== 1'b0 || o_instr_execute !== 1'b0 ||
            o_imm_valid !== 1'b0 || o_decoder_error !== 1'b0)
            report_failure("a status flag is high after reset");
        if (o_instr_type !== INSTR_TYPE_NONE)
            report_mismatch("type after reset", 32'(o_instr_type), 32'(INSTR_TYPE_NONE));
        if (o_alu_opcode !== ALU_OP_NOP)
            report_mismatch("opcode after reset", 32'(o_alu_opcode), 32'(ALU_OP_NOP));
        if (o_alu_reg_dest !== ALU_REG_NONE)
            report_mismatch("destination after reset", 32'(o_alu_reg_dest), 32'(ALU_REG_NONE));
        finish_test("test 0 (after reset)", errors_before);

        fd = $fopen("test/decoder_testdata.txt", "r");
        if (fd == 0) begin
            report_failure("the testdata file could not be opened");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 2 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                                     v_count, v_nibs, v_p, v_type, v_dest, v_src1,
                                     v_src2, v_op, v_begin, v_end, v_push, v_err);
                    if (fields == 12) begin
                        number++;
                        run_line(number);
                    end
                end
            end
            $fclose(fd);
        end

        $display("%0d tests passed, %0d tests failed", passed, failed);
        if (failed == 0 && errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
src/saturn_decode_pkg.sv
src/nibble_if.sv
src/nibble_sequencer.sv
src/opcode_classifier.sv
src/uop_register.sv
src/saturn_nibble_decoder.sv
test/tb_saturn_nibble_decoder.sv
